//--- Bender.yml
package:
  name: ndn_fib

sources:
  - hw/ndn_fib_pkg.sv
  - hw/fib_cmd_if.sv
  - hw/fib_res_if.sv
  - hw/prefix_hash.sv
  - hw/fib_cmd_decode.sv
  - hw/fib_lpm_engine.sv
  - hw/fib_result_ctrl.sv
  - hw/fib_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/fib_tb.sv

//--- hw/fib_cmd_decode.sv
/*
 * Decode stage of the FIB. Latches learn and lookup strobes into one slot each,
 * drops zero-length learns and issues slots to the engine, lookups first.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_cmd_decode (
    input  logic                              clk,
    input  logic                              rst,
    // Learn requests from the data path
    input  logic                              data_ready,
    input  logic [ndn_fib_pkg::PREFIX_W-1:0]  data_in_prefix,
    input  logic [ndn_fib_pkg::LEN_W-1:0]     data_in_len,
    // Lookup requests from the PIT side
    input  logic                              fib_out_bit,
    input  logic [ndn_fib_pkg::PREFIX_W-1:0]  pit_in_prefix,
    input  logic [ndn_fib_pkg::LEN_W-1:0]     pit_in_len,
    input  logic                              res_busy,
    output logic                              busy,
    fib_cmd_if.decoder                        cmd
);
    import ndn_fib_pkg::*;

    // Pending slots
    logic                learn_pend;
    logic [PREFIX_W-1:0] learn_prefix;
    logic [LEN_W-1:0]    learn_len;
    logic                lookup_pend;
    logic [PREFIX_W-1:0] lookup_prefix;
    logic [LEN_W-1:0]    lookup_len;

    logic issue_learn;
    logic issue_lookup;

    // Lookup wins whenever the engine is free
    assign issue_lookup = lookup_pend && !cmd.eng_busy;
    // Learn also needs the result stage idle, since it ends in a PIT query
    assign issue_learn  = learn_pend && !lookup_pend && !cmd.eng_busy && !res_busy;

    assign cmd.cmd_valid  = issue_lookup || issue_learn;
    assign cmd.cmd_op     = issue_lookup ? OP_LOOKUP : OP_LEARN;
    assign cmd.cmd_prefix = issue_lookup ? lookup_prefix : learn_prefix;
    assign cmd.cmd_len    = issue_lookup ? lookup_len : learn_len;

    assign busy = learn_pend || lookup_pend || cmd.eng_busy || res_busy;

    // Slot flags
    always_ff @(posedge clk) begin
        if (rst) begin
            learn_pend  <= 1'b0;
            lookup_pend <= 1'b0;
        end else begin
            // A strobe into an occupied slot is lost
            if (issue_learn) begin
                learn_pend <= 1'b0;
            end else if (data_ready && !learn_pend && data_in_len != '0) begin
                learn_pend <= 1'b1;
            end
            if (issue_lookup) begin
                lookup_pend <= 1'b0;
            end else if (fib_out_bit && !lookup_pend) begin
                lookup_pend <= 1'b1;
            end
        end
    end

    // Slot contents, captured only when the slot is free
    always_ff @(posedge clk) begin
        if (data_ready && !learn_pend) begin
            learn_prefix <= data_in_prefix;
            learn_len    <= data_in_len;
        end
        if (fib_out_bit && !lookup_pend) begin
            lookup_prefix <= pit_in_prefix;
            lookup_len    <= pit_in_len;
        end
    end

endmodule

`default_nettype wire

//--- hw/fib_cmd_if.sv
/*
 * One decoded command from the decode stage to the execute stage.
 * cmd_valid is a single-cycle strobe, only raised while eng_busy is low.
 */
`timescale 1ns/1ps
`default_nettype none

interface fib_cmd_if;
    import ndn_fib_pkg::*;

    logic                cmd_valid;
    fib_op_e             cmd_op;
    logic [PREFIX_W-1:0] cmd_prefix;
    logic [LEN_W-1:0]    cmd_len;
    // Level from the engine, high while a command or the table clear runs
    logic                eng_busy;

    modport decoder (
        output cmd_valid, cmd_op, cmd_prefix, cmd_len,
        input  eng_busy
    );

    modport engine (
        input  cmd_valid, cmd_op, cmd_prefix, cmd_len,
        output eng_busy
    );

endinterface

`default_nettype wire

//--- hw/fib_lpm_engine.sv
/*
 * Execute stage of the FIB. Owns the valid-bit table (one row per length),
 * sets bits on learns and runs longest-prefix probing on lookups.
 * The table is swept clear row by row after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_lpm_engine (
    input  logic      clk,
    input  logic      rst,
    fib_cmd_if.engine cmd,
    fib_res_if.engine res
);
    import ndn_fib_pkg::*;

    localparam int unsigned TBL_DEPTH = 1 << HASH_W;

    engine_state_e state;

    // Valid bits, indexed [length][hash]
    logic [TBL_DEPTH-1:0] valid_tbl [NUM_LENS];

    // Post-reset clear sweep
    logic             clr_active;
    logic [LEN_W-1:0] clr_row;

    // Command being worked on
    logic [PREFIX_W-1:0] cur_prefix;
    logic [LEN_W-1:0]    cur_len;

    // Hash unit inputs and result
    logic [PREFIX_W-1:0] hash_prefix;
    logic [LEN_W-1:0]    hash_len;
    logic [HASH_W-1:0]   hash_idx;
    logic                probe_bit;

    // Idle feeds the incoming command so the first hash lands one cycle after issue
    assign hash_prefix = (state == ENG_IDLE) ? cmd.cmd_prefix : cur_prefix;
    assign hash_len    = (state == ENG_IDLE) ? cmd.cmd_len : cur_len;

    prefix_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (hash_prefix),
        .len    (hash_len),
        .index  (hash_idx)
    );

    assign probe_bit = valid_tbl[cur_len][hash_idx];

    // Held through the final pulse so the decoder cannot issue early
    assign cmd.eng_busy = clr_active || (state != ENG_IDLE)
                        || res.learn_done || res.lookup_hit || res.lookup_miss;

    // Clear sweep, 64 cycles after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_active <= 1'b1;
            clr_row    <= '0;
        end else if (clr_active) begin
            clr_row <= clr_row + 1'b1;
            if (clr_row == LEN_W'(NUM_LENS - 1)) begin
                clr_active <= 1'b0;
            end
        end
    end

    // Table writes
    always_ff @(posedge clk) begin
        if (clr_active) begin
            valid_tbl[clr_row] <= '0;
        end else if (state == ENG_WRITE) begin
            valid_tbl[cur_len][hash_idx] <= 1'b1;
        end
    end

    // Sequencing and completion pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ENG_IDLE;
            res.learn_done  <= 1'b0;
            res.lookup_hit  <= 1'b0;
            res.lookup_miss <= 1'b0;
        end else begin
            res.learn_done  <= 1'b0;
            res.lookup_hit  <= 1'b0;
            res.lookup_miss <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (cmd.cmd_valid) begin
                        state <= (cmd.cmd_op == OP_LEARN) ? ENG_WRITE : ENG_PROBE;
                    end
                end
                ENG_WRITE: begin
                    res.learn_done <= 1'b1;
                    state          <= ENG_IDLE;
                end
                // One cycle for the re-hash at the shorter length
                ENG_HASH: state <= ENG_PROBE;
                ENG_PROBE: begin
                    if (probe_bit && cur_len != '0) begin
                        res.lookup_hit <= 1'b1;
                        state          <= ENG_IDLE;
                    end else if (cur_len <= LEN_W'(1)) begin
                        // Nothing left to try
                        res.lookup_miss <= 1'b1;
                        state           <= ENG_IDLE;
                    end else begin
                        state <= ENG_HASH;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Working prefix and length, reported alongside the pulses
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && cmd.cmd_valid) begin
            cur_prefix <= cmd.cmd_prefix;
            cur_len    <= cmd.cmd_len;
        end else if (state == ENG_PROBE && !probe_bit && cur_len > LEN_W'(1)) begin
            cur_len <= cur_len - 1'b1;
        end
        res.res_prefix <= cur_prefix;
        res.res_len    <= cur_len;
    end

endmodule

`default_nettype wire

//--- hw/fib_res_if.sv
/*
 * Completion pulses from the execute stage to the result stage.
 * res_prefix and res_len qualify whichever pulse is high in that cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface fib_res_if;
    import ndn_fib_pkg::*;

    logic                learn_done;
    logic                lookup_hit;
    logic                lookup_miss;
    logic [PREFIX_W-1:0] res_prefix;
    logic [LEN_W-1:0]    res_len;
    // Level from the result stage, high during the PIT query and transfer
    logic                res_busy;

    modport engine (
        output learn_done, lookup_hit, lookup_miss, res_prefix, res_len
    );

    modport result (
        input  learn_done, lookup_hit, lookup_miss, res_prefix, res_len,
        output res_busy
    );

endinterface

`default_nettype wire

//--- hw/fib_result_ctrl.sv
/*
 * Result stage of the FIB. Queries the PIT after a learn, waits for the verdict
 * and streams DATA_BYTES payload bytes on accept. Lookup results bypass the FSM.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_result_ctrl #(
    parameter int unsigned DATA_BYTES = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    // PIT verdict
    input  logic                              rejected,
    input  logic                              start_send_to_pit,
    input  logic [7:0]                        data_in,
    // PIT query
    output logic                              prefix_ready,
    output logic [ndn_fib_pkg::PREFIX_W-1:0]  pit_out_prefix,
    output logic [ndn_fib_pkg::LEN_W-1:0]     pit_out_len,
    // Payload stream
    output logic [7:0]                        out_data,
    output logic                              out_valid,
    // Lookup result
    output logic [ndn_fib_pkg::PREFIX_W-1:0]  prefix_out,
    output logic [ndn_fib_pkg::LEN_W-1:0]     len_out,
    output logic                              match_valid,
    output logic                              no_match,
    fib_res_if.result                         res
);
    import ndn_fib_pkg::*;

    // Enough for up to 1023 bytes
    localparam int unsigned CNT_W = 10;

    result_state_e    state;
    logic [CNT_W-1:0] byte_cnt;

    assign prefix_ready = (state == RES_QUERY);
    assign out_valid    = (state == RES_TRANSFER);
    assign res.res_busy = (state != RES_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RES_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                RES_IDLE: begin
                    if (res.learn_done) begin
                        state <= RES_QUERY;
                    end
                end
                RES_QUERY: state <= RES_WAIT_PIT;
                RES_WAIT_PIT: begin
                    // Reject takes priority over a simultaneous accept
                    if (rejected) begin
                        state <= RES_IDLE;
                    end else if (start_send_to_pit) begin
                        state    <= RES_TRANSFER;
                        byte_cnt <= '0;
                    end
                end
                RES_TRANSFER: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == CNT_W'(DATA_BYTES - 1)) begin
                        state <= RES_IDLE;
                    end
                end
                default: state <= RES_IDLE;
            endcase
        end
    end

    // Query fields and one-cycle delayed payload
    always_ff @(posedge clk) begin
        if (state == RES_IDLE && res.learn_done) begin
            pit_out_prefix <= res.res_prefix;
            pit_out_len    <= res.res_len;
        end
        out_data <= data_in;
    end

    // Lookup reporting, runs alongside a transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            match_valid <= 1'b0;
            no_match    <= 1'b0;
        end else begin
            match_valid <= res.lookup_hit;
            no_match    <= res.lookup_miss;
        end
    end

    always_ff @(posedge clk) begin
        if (res.lookup_hit || res.lookup_miss) begin
            prefix_out <= mask_prefix(res.res_prefix, res.res_len);
            len_out    <= res.res_len;
        end
    end

endmodule

`default_nettype wire

//--- hw/fib_top.sv
/*
 * Top level of the NDN FIB. Connects decode, execute and result stages
 * through the command and result interfaces and exposes plain ports.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_top #(
    parameter int unsigned DATA_BYTES = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    // Learn side
    input  logic                              data_ready,
    input  logic [ndn_fib_pkg::PREFIX_W-1:0]  data_in_prefix,
    input  logic [ndn_fib_pkg::LEN_W-1:0]     data_in_len,
    input  logic [7:0]                        data_in,
    // Lookup side
    input  logic                              fib_out_bit,
    input  logic [ndn_fib_pkg::PREFIX_W-1:0]  pit_in_prefix,
    input  logic [ndn_fib_pkg::LEN_W-1:0]     pit_in_len,
    // PIT replies
    input  logic                              rejected,
    input  logic                              start_send_to_pit,
    // PIT query
    output logic                              prefix_ready,
    output logic [ndn_fib_pkg::PREFIX_W-1:0]  pit_out_prefix,
    output logic [ndn_fib_pkg::LEN_W-1:0]     pit_out_len,
    // Payload
    output logic [7:0]                        out_data,
    output logic                              out_valid,
    // Lookup result
    output logic [ndn_fib_pkg::PREFIX_W-1:0]  prefix_out,
    output logic [ndn_fib_pkg::LEN_W-1:0]     len_out,
    output logic                              match_valid,
    output logic                              no_match,
    output logic                              busy
);

    fib_cmd_if cmd_if ();
    fib_res_if res_if ();

    fib_cmd_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .data_ready     (data_ready),
        .data_in_prefix (data_in_prefix),
        .data_in_len    (data_in_len),
        .fib_out_bit    (fib_out_bit),
        .pit_in_prefix  (pit_in_prefix),
        .pit_in_len     (pit_in_len),
        .res_busy       (res_if.res_busy),
        .busy           (busy),
        .cmd            (cmd_if.decoder)
    );

    fib_lpm_engine u_engine (
        .clk (clk),
        .rst (rst),
        .cmd (cmd_if.engine),
        .res (res_if.engine)
    );

    fib_result_ctrl #(
        .DATA_BYTES (DATA_BYTES)
    ) u_result (
        .clk               (clk),
        .rst               (rst),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .data_in           (data_in),
        .prefix_ready      (prefix_ready),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_len       (pit_out_len),
        .out_data          (out_data),
        .out_valid         (out_valid),
        .prefix_out        (prefix_out),
        .len_out           (len_out),
        .match_valid       (match_valid),
        .no_match          (no_match),
        .res               (res_if.result)
    );

endmodule

`default_nettype wire

//--- hw/ndn_fib_pkg.sv
/*
 * Shared widths, opcodes and state encodings for the NDN FIB block.
 * Modules import it inside their bodies and use scoped names in their port lists.
 */
`default_nettype none

package ndn_fib_pkg;

    // Name prefix, counted from the MSB
    localparam int unsigned PREFIX_W = 64;
    // Prefix length in bits
    localparam int unsigned LEN_W = 6;
    // Table index, 1024 entries per row
    localparam int unsigned HASH_W = 10;
    // One table row per prefix length
    localparam int unsigned NUM_LENS = 64;

    // Command kinds carried from decode to execute
    typedef enum logic {
        OP_LEARN,
        OP_LOOKUP
    } fib_op_e;

    // Execute stage sequencing
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_HASH,
        ENG_WRITE,
        ENG_PROBE
    } engine_state_e;

    // PIT query and payload transfer sequencing
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_QUERY,
        RES_WAIT_PIT,
        RES_TRANSFER
    } result_state_e;

    // Keep the top len bits of a prefix and clear the rest
    function automatic logic [PREFIX_W-1:0] mask_prefix(
        input logic [PREFIX_W-1:0] prefix,
        input logic [LEN_W-1:0] len
    );
        return prefix & ~({PREFIX_W{1'b1}} >> len);
    endfunction

endpackage

`default_nettype wire

//--- hw/prefix_hash.sv
/*
 * Hashes a length-masked prefix into a table index.
 * XOR fold of ten-bit chunks plus the length, registered with one cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module prefix_hash (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [ndn_fib_pkg::PREFIX_W-1:0]  prefix,
    input  logic [ndn_fib_pkg::LEN_W-1:0]     len,
    output logic [ndn_fib_pkg::HASH_W-1:0]    index
);
    import ndn_fib_pkg::*;

    // Six full chunks and a four-bit tail for a 64-bit prefix
    localparam int unsigned NUM_FULL = PREFIX_W / HASH_W;
    localparam int unsigned TAIL_W   = PREFIX_W % HASH_W;

    logic [PREFIX_W-1:0] masked;
    logic [HASH_W-1:0]   fold;

    always_comb begin
        masked = mask_prefix(prefix, len);
        // Length enters the fold zero-extended
        fold = {{(HASH_W-LEN_W){1'b0}}, len};
        // Full chunks taken from the MSB end
        for (int i = 0; i < NUM_FULL; i++) begin
            fold ^= masked[PREFIX_W-1-i*HASH_W -: HASH_W];
        end
        // Tail chunk padded with zeros at the top
        fold ^= {{(HASH_W-TAIL_W){1'b0}}, masked[TAIL_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else begin
            index <= fold;
        end
    end

endmodule

`default_nettype wire

//--- sim/fib_tb_model.svh
/*
 * Reference model for the FIB testbench. Holds a software copy of the valid bits
 * and the prefix hash, written bit by bit from the hash rule. Included in fib_tb.
 */
`ifndef FIB_TB_MODEL_SVH
`define FIB_TB_MODEL_SVH

// Software valid bits, [length][index]
bit [1023:0] model_tbl [64];

// Keep the top len bits of a prefix
function automatic logic [63:0] keep_top_bits(input logic [63:0] prefix, input int len);
    logic [63:0] kept;
    kept = '0;
    for (int i = 0; i < len; i++) begin
        kept[63-i] = prefix[63-i];
    end
    return kept;
endfunction

function automatic logic [9:0] model_hash(input logic [63:0] prefix, input int len);
    logic [63:0] kept;
    logic [9:0]  h;
    kept = keep_top_bits(prefix, len);
    h = len[9:0];
    // Full chunks end at bit 4, so bit p folds onto hash bit (p-4) mod 10
    for (int p = 4; p < 64; p++) begin
        h[(p-4)%10] ^= kept[p];
    end
    // Tail chunk is bits 3..0, zero padded above
    for (int p = 0; p < 4; p++) begin
        h[p] ^= kept[p];
    end
    return h;
endfunction

function automatic void model_learn(input logic [63:0] prefix, input int len);
    // Length 0 never becomes an entry
    if (len != 0) begin
        model_tbl[len][model_hash(prefix, len)] = 1'b1;
    end
endfunction

// Longest set length at or below len, 0 for a miss
function automatic int model_lpm(input logic [63:0] prefix, input int len);
    for (int l = len; l >= 1; l--) begin
        if (model_tbl[l][model_hash(prefix, l)]) begin
            return l;
        end
    end
    return 0;
endfunction

function automatic void model_clear();
    foreach (model_tbl[i]) begin
        model_tbl[i] = '0;
    end
endfunction

`endif

//--- sim/fib_tb.sv
/*
 * Testbench for fib_top. Applies a table of learn, lookup and reset rows,
 * answers the PIT query and checks query, payload and lookup outputs against a model.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_tb;
    localparam int DATA_BYTES = 16;
    localparam int TIMEOUT    = 2000;
    localparam int NUM_ROWS   = 16;

    typedef enum {K_LEARN_ACCEPT, K_LEARN_REJECT, K_LOOKUP, K_RESET} kind_e;

    typedef struct {
        kind_e       kind;
        logic [63:0] prefix;
        int          len;
        bit          exp_hit;
        int          exp_len;
    } row_t;

    logic        clk;
    logic        rst;
    logic        data_ready;
    logic [63:0] data_in_prefix;
    logic [5:0]  data_in_len;
    logic [7:0]  data_in;
    logic        fib_out_bit;
    logic [63:0] pit_in_prefix;
    logic [5:0]  pit_in_len;
    logic        rejected;
    logic        start_send_to_pit;
    logic        prefix_ready;
    logic [63:0] pit_out_prefix;
    logic [5:0]  pit_out_len;
    logic [7:0]  out_data;
    logic        out_valid;
    logic [63:0] prefix_out;
    logic [5:0]  len_out;
    logic        match_valid;
    logic        no_match;
    logic        busy;

    row_t rows [NUM_ROWS];

    // Event counts kept by the output monitor
    int ready_cnt;
    int hit_cnt;
    int miss_cnt;
    int valid_cnt;
    int run_len;
    logic [7:0] prev_byte;
    integer seed = 91682;

    `include "fib_tb_model.svh"

    fib_top #(
        .DATA_BYTES (DATA_BYTES)
    ) UUT (
        .clk               (clk),
        .rst               (rst),
        .data_ready        (data_ready),
        .data_in_prefix    (data_in_prefix),
        .data_in_len       (data_in_len),
        .data_in           (data_in),
        .fib_out_bit       (fib_out_bit),
        .pit_in_prefix     (pit_in_prefix),
        .pit_in_len        (pit_in_len),
        .rejected          (rejected),
        .start_send_to_pit (start_send_to_pit),
        .prefix_ready      (prefix_ready),
        .pit_out_prefix    (pit_out_prefix),
        .pit_out_len       (pit_out_len),
        .out_data          (out_data),
        .out_valid         (out_valid),
        .prefix_out        (prefix_out),
        .len_out           (len_out),
        .match_valid       (match_valid),
        .no_match          (no_match),
        .busy              (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else
            abort_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Prefixes sharing top bits at 8, 16 and 24, a deep entry and a short miss
    task automatic load_rows();
        rows[0]  = '{K_LEARN_ACCEPT, 64'hA5C3_1E7F_0B92_D468, 8, 0, 0};
        rows[1]  = '{K_LEARN_ACCEPT, 64'hA5C3_5500_1234_5678, 16, 0, 0};
        rows[2]  = '{K_LEARN_REJECT, 64'hA5C3_1E7F_0B92_D468, 24, 0, 0};
        rows[3]  = '{K_LOOKUP,       64'hA5C3_1E7F_0B92_D468, 32, 0, 0};
        rows[4]  = '{K_LOOKUP,       64'hA5C3_1E7F_0B92_D468, 20, 0, 0};
        rows[5]  = '{K_LOOKUP,       64'hA5C3_1E7F_0B92_D468, 12, 0, 0};
        rows[6]  = '{K_LOOKUP,       64'hA5C3_1E7F_0B92_D468, 4, 0, 0};
        rows[7]  = '{K_LEARN_ACCEPT, 64'h0123_4567_89AB_CDEF, 40, 0, 0};
        rows[8]  = '{K_LOOKUP,       64'h0123_4567_89AB_FFFF, 63, 0, 0};
        rows[9]  = '{K_LEARN_ACCEPT, 64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 0};
        rows[10] = '{K_LOOKUP,       64'hFFFF_FFFF_FFFF_FFFF, 63, 0, 0};
        rows[11] = '{K_LOOKUP,       64'h1234_5678_9ABC_DEF0, 0, 0, 0};
        rows[12] = '{K_RESET,        64'h0, 0, 0, 0};
        rows[13] = '{K_LOOKUP,       64'hA5C3_1E7F_0B92_D468, 32, 0, 0};
        rows[14] = '{K_LEARN_ACCEPT, 64'hDEAD_BEEF_0000_0000, 60, 0, 0};
        rows[15] = '{K_LOOKUP,       64'hDEAD_BEEF_0000_0000, 60, 0, 0};
    endtask

    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        while (busy !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout while waiting for busy to go low");
            end
        end
    endtask

    task automatic wait_prefix_ready();
        int cycles;
        cycles = 0;
        while (prefix_ready !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout while waiting for the PIT query pulse");
            end
        end
    endtask

    task automatic wait_lookup_result();
        int cycles;
        cycles = 0;
        while (match_valid !== 1'b1 && no_match !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout while waiting for a lookup result");
            end
        end
    endtask

    // Reset held for 10 cycles, then the table clear sweep runs
    task automatic pulse_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        wait_busy_low();
    endtask

    task automatic apply_row(input int i);
        int ready_before;
        int valid_before;
        int result_before;
        int exp_valid;
        ready_before  = ready_cnt;
        valid_before  = valid_cnt;
        result_before = hit_cnt + miss_cnt;
        case (rows[i].kind)
            K_LEARN_ACCEPT, K_LEARN_REJECT: begin
                // Bit is set at learn time, whatever the PIT answers
                model_learn(rows[i].prefix, rows[i].len);
                data_in_prefix = rows[i].prefix;
                data_in_len    = 6'(rows[i].len);
                data_ready     = 1'b1;
                @(negedge clk);
                data_ready = 1'b0;
                if (rows[i].len != 0) begin
                    wait_prefix_ready();
                    check_hex("pit_out_prefix", pit_out_prefix, rows[i].prefix);
                    check_hex("pit_out_len", pit_out_len, rows[i].len);
                    @(negedge clk);
                    start_send_to_pit = (rows[i].kind == K_LEARN_ACCEPT);
                    rejected          = (rows[i].kind == K_LEARN_REJECT);
                    @(negedge clk);
                    start_send_to_pit = 1'b0;
                    rejected          = 1'b0;
                end
                wait_busy_low();
                repeat (2) @(negedge clk);
                check_hex("prefix_ready count", ready_cnt - ready_before, rows[i].len != 0);
                exp_valid = (rows[i].kind == K_LEARN_ACCEPT && rows[i].len != 0) ? DATA_BYTES : 0;
                check_hex("out_valid count", valid_cnt - valid_before, exp_valid);
            end
            K_LOOKUP: begin
                rows[i].exp_len = model_lpm(rows[i].prefix, rows[i].len);
                rows[i].exp_hit = (rows[i].exp_len != 0);
                pit_in_prefix = rows[i].prefix;
                pit_in_len    = 6'(rows[i].len);
                fib_out_bit   = 1'b1;
                @(negedge clk);
                fib_out_bit = 1'b0;
                wait_lookup_result();
                check_hex("match_valid", match_valid, rows[i].exp_hit);
                check_hex("no_match", no_match, !rows[i].exp_hit);
                if (rows[i].exp_hit) begin
                    check_hex("len_out", len_out, rows[i].exp_len);
                    check_hex("prefix_out", prefix_out,
                              keep_top_bits(rows[i].prefix, rows[i].exp_len));
                end
                wait_busy_low();
                repeat (2) @(negedge clk);
                check_hex("lookup result count", hit_cnt + miss_cnt - result_before, 1);
            end
            K_RESET: begin
                model_clear();
                pulse_reset();
            end
            default: abort_run("unknown row kind in the stimulus table");
        endcase
    endtask

    // Payload source and output monitor, sampled at falling edges
    initial begin
        data_in   = 8'h00;
        prev_byte = 8'h00;
        ready_cnt = 0;
        hit_cnt   = 0;
        miss_cnt  = 0;
        valid_cnt = 0;
        run_len   = 0;
        forever begin
            @(negedge clk);
            if (prefix_ready === 1'b1) begin
                ready_cnt++;
            end
            if (match_valid === 1'b1) begin
                hit_cnt++;
            end
            if (no_match === 1'b1) begin
                miss_cnt++;
            end
            if (out_valid === 1'b1) begin
                // Byte driven one cycle earlier
                check_hex("out_data", out_data, prev_byte);
                valid_cnt++;
                run_len++;
            end else if (run_len != 0) begin
                check_hex("out_valid run length", run_len, DATA_BYTES);
                run_len = 0;
            end
            prev_byte = 8'($random(seed));
            data_in   = prev_byte;
        end
    end

    initial begin
        rst               = 1'b1;
        data_ready        = 1'b0;
        data_in_prefix    = '0;
        data_in_len       = '0;
        fib_out_bit       = 1'b0;
        pit_in_prefix     = '0;
        pit_in_len        = '0;
        rejected          = 1'b0;
        start_send_to_pit = 1'b0;
        model_clear();
        load_rows();
        pulse_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
hw/ndn_fib_pkg.sv
hw/fib_cmd_if.sv
hw/fib_res_if.sv
hw/prefix_hash.sv
hw/fib_cmd_decode.sv
hw/fib_lpm_engine.sv
hw/fib_result_ctrl.sv
hw/fib_top.sv
sim/fib_tb.sv
